//--- c1Pkg.sv
`default_nettype none

package c1Pkg;

	// One main CPU bus cycle, strobes active high
	typedef struct packed {
		logic [6:0] addr;		// A23 down to A17
		logic upperStrobe;		// UDS
		logic lowerStrobe;		// LDS
		logic read;			// High for read, low for write
		logic strobe;			// AS
		logic [7:0] writeData;	// Upper data byte D15..D8
	} cpuBus_t;

	// Decoded region of the current cycle
	typedef enum logic [3:0] {
		zoneRom,
		zoneWorkRam,
		zonePort,
		zoneCtrl1,
		zoneSoundCom,
		zoneCtrl2,
		zoneStatusB,
		zoneDip,
		zoneBitWrite,
		zoneVideo,
		zonePalette,
		zoneCard,
		zoneSysRom,
		zoneBackupRam,
		zoneNone
	} c1Zone_e;

	// Byte lane pair of a 16 bit memory
	typedef struct packed {
		logic upper;	// D15..D8
		logic lower;	// D7..D0
	} laneSel_t;

	// Memory and I/O enables, all active high
	typedef struct packed {
		laneSel_t romOe;		// Program ROM
		laneSel_t portOe;		// Expansion port
		laneSel_t portWe;
		laneSel_t workRamRead;
		laneSel_t workRamWrite;
		laneSel_t sysRomOe;		// System ROM
		laneSel_t backupRamOe;
		laneSel_t backupRamWe;
		logic videoOe;			// Video controller
		logic videoWe;
		logic cardOe;			// Memory card
		logic cardWe;
		logic cardSelect;
		logic dipRead0;
		logic dipRead1;
		logic bitWrite0;
		logic bitWrite1;
		logic paletteSelect;
	} memSelects_t;

	typedef struct packed {
		logic [9:0] player1;
		logic [9:0] player2;
	} playerInputs_t;

	localparam int cardWaitStates = 2;		// Card zone
	localparam int romSlowWaitStates = 1;	// Extra cycle with romWait
	localparam int waitCountBits = 2;		// Wide enough for the largest wait

	// DTACK FSM encoding
	localparam logic [1:0] stateIdle = 2'd0;
	localparam logic [1:0] stateCounting = 2'd1;
	localparam logic [1:0] stateWaitExternal = 2'd2;
	localparam logic [1:0] stateAcknowledged = 2'd3;

	// Port wait setting where the port itself ends the cycle
	localparam logic [1:0] portWaitExternal = 2'd3;

endpackage

`default_nettype wire

//--- c1AddressDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module c1AddressDecoder import c1Pkg::*; (
	input wire cpuBus_t bus,
	output c1Zone_e zone,
	output memSelects_t selects
);

	c1Zone_e ioZone;		// Sub decode of 300000~3FFFFF
	logic ioRegion;		// Whole I/O block
	logic readCycle;		// AS qualified read
	logic writeCycle;		// AS qualified write

	// Spread one enable onto whichever lanes are strobed
	function automatic laneSel_t laneSel(input logic enable, input cpuBus_t cycle);
		laneSel_t lanes;
		lanes.upper = enable & cycle.upperStrobe;
		lanes.lower = enable & cycle.lowerStrobe;
		return lanes;
	endfunction

	assign ioRegion = (bus.addr[6:3] == 4'b0011);
	assign readCycle = bus.strobe & bus.read;
	assign writeCycle = bus.strobe & ~bus.read;

	// I/O block, registers on the upper lane
	always_comb begin
		ioZone = zoneNone;
		if (bus.addr[2:0] == 3'b110) begin
			ioZone = zoneVideo;		// 3C0000~3DFFFF, either lane
		end else if (bus.upperStrobe) begin
			case (bus.addr[2:0])
				3'b000: ioZone = zoneCtrl1;		// 300000~31FFFE
				3'b001: ioZone = zoneSoundCom;	// 320000~33FFFE
				3'b010: ioZone = zoneCtrl2;		// 340000~35FFFE
				3'b100: ioZone = zoneStatusB;	// 380000~39FFFE
				default: ioZone = zoneNone;		// 36xxxx, 3Axxxx, 3Exxxx
			endcase
		end else if (bus.lowerStrobe) begin
			// Odd bytes only
			case (bus.addr[2:1])
				2'b00: ioZone = zoneDip;		// 30xxxx to 33xxxx
				2'b10: ioZone = zoneBitWrite;	// 38xxxx to 3Bxxxx
				default: ioZone = zoneNone;
			endcase
		end
	end

	// Top level memory map
	always_comb begin
		casez (bus.addr)
			7'b0000???: zone = zoneRom;			// 000000~0FFFFF
			7'b0001???: zone = zoneWorkRam;		// 100000~1FFFFF
			7'b0010???: zone = zonePort;		// 200000~2FFFFF
			7'b0011???: zone = ioZone;			// 300000~3FFFFF
			7'b01?????: zone = zonePalette;		// 400000~7FFFFF
			7'b10?????: zone = zoneCard;		// 800000~BFFFFF
			7'b1100???: zone = zoneSysRom;		// C00000~CFFFFF
			7'b1101???: zone = zoneBackupRam;	// D00000~DFFFFF
			default: zone = zoneNone;			// E00000 and up unmapped
		endcase
	end

	always_comb begin
		selects = '0;

		// Word memories, per lane
		selects.romOe = laneSel(readCycle && zone == zoneRom, bus);
		selects.portOe = laneSel(readCycle && zone == zonePort, bus);
		selects.portWe = laneSel(writeCycle && zone == zonePort, bus);
		selects.workRamRead = laneSel(readCycle && zone == zoneWorkRam, bus);
		selects.workRamWrite = laneSel(writeCycle && zone == zoneWorkRam, bus);
		selects.sysRomOe = laneSel(readCycle && zone == zoneSysRom, bus);
		selects.backupRamOe = laneSel(readCycle && zone == zoneBackupRam, bus);
		selects.backupRamWe = laneSel(writeCycle && zone == zoneBackupRam, bus);

		// Video controller sits on the upper byte
		selects.videoOe = readCycle & bus.upperStrobe & (zone == zoneVideo);
		selects.videoWe = writeCycle & bus.upperStrobe & (zone == zoneVideo);

		// Card is byte wide on the odd lane
		selects.cardOe = readCycle & bus.lowerStrobe & (zone == zoneCard);
		selects.cardWe = writeCycle & bus.lowerStrobe & (zone == zoneCard);
		selects.cardSelect = selects.cardOe | selects.cardWe;

		// DIP reads and bit writes straight from the address so word access still hits
		selects.dipRead0 = readCycle & bus.lowerStrobe & ioRegion & (bus.addr[2:0] == 3'b000);
		selects.dipRead1 = readCycle & bus.lowerStrobe & ioRegion & (bus.addr[2:0] == 3'b001);
		selects.bitWrite0 = writeCycle & bus.lowerStrobe & ioRegion & (bus.addr[2:0] == 3'b100);
		selects.bitWrite1 = writeCycle & bus.lowerStrobe & ioRegion & (bus.addr[2:0] == 3'b101);

		selects.paletteSelect = bus.strobe & (zone == zonePalette);	// Any lane, any direction
	end

endmodule

`default_nettype wire

//--- c1WaitStates.sv
`timescale 1ns/100ps
`default_nettype none

module c1WaitStates import c1Pkg::*; (
	input wire CLK_68KCLK,
	input wire reset,
	input wire strobe,
	input wire c1Zone_e zone,
	input wire romWait,
	input wire [1:0] portWait,
	input wire portDtack,
	output logic dtack
);

	logic [1:0] state;
	logic [1:0] stateNext;
	logic [waitCountBits-1:0] count;		// Wait cycles left
	logic [waitCountBits-1:0] countNext;
	logic [waitCountBits-1:0] waitLoad;	// Wait cycles for this zone
	logic external;						// Port ends the cycle itself

	// Zone dependent wait
	always_comb begin
		waitLoad = '0;
		external = 1'b0;
		case (zone)
			zoneRom: begin
				if (romWait)
					waitLoad = waitCountBits'(romSlowWaitStates);	// Slow cart ROM
			end
			zonePort: begin
				if (portWait == portWaitExternal)
					external = 1'b1;		// Wait for portDtack
				else
					waitLoad = portWait;	// 0 to 2 waits
			end
			zoneCard: waitLoad = waitCountBits'(cardWaitStates);
			default: waitLoad = '0;		// Everything else runs at full speed
		endcase
	end

	always_comb begin
		stateNext = state;
		countNext = count;
		case (state)
			stateIdle: begin
				if (strobe) begin		// New bus cycle
					if (external) begin
						stateNext = stateWaitExternal;
					end else begin
						stateNext = stateCounting;
						countNext = waitLoad;
					end
				end
			end
			stateCounting: begin
				if (!strobe)
					stateNext = stateIdle;				// Aborted cycle
				else if (count == '0)
					stateNext = stateAcknowledged;
				else
					countNext = count - 1'b1;
			end
			stateWaitExternal: begin
				if (!strobe) begin
					stateNext = stateIdle;
				end else if (portDtack) begin
					stateNext = stateCounting;	// One more clock then DTACK
					countNext = '0;
				end
			end
			stateAcknowledged: begin
				if (!strobe)
					stateNext = stateIdle;	// Hold until AS released
			end
			default: stateNext = stateIdle;
		endcase
	end

	always_ff @(posedge CLK_68KCLK) begin
		if (reset) begin
			state <= stateIdle;
			count <= '0;
		end else begin
			state <= stateNext;
			count <= countNext;
		end
	end

	assign dtack = (state == stateAcknowledged);	// Registered, no glitches

endmodule

`default_nettype wire

//--- c1InputPorts.sv
`timescale 1ns/100ps
`default_nettype none

module c1InputPorts import c1Pkg::*; (
	input wire CLK_68KCLK,
	input wire reset,
	input wire playerInputs_t player,
	input wire [1:0] cardDetect,
	input wire writeProtect,
	input wire systemMode,
	input wire c1Zone_e zone,
	output logic [7:0] inputData
);

	// All pin inputs sampled together
	typedef struct packed {
		playerInputs_t player;
		logic [1:0] cardDetect;
		logic writeProtect;
		logic systemMode;
	} pinSample_t;

	pinSample_t pins;			// Raw pins
	pinSample_t pinsSampled;		// One clock later

	assign pins = '{player, cardDetect, writeProtect, systemMode};

	// Settling register for the asynchronous pins
	always_ff @(posedge CLK_68KCLK) begin
		if (reset)
			pinsSampled <= '0;
		else
			pinsSampled <= pins;
	end

	// Read mux onto the upper data byte
	always_comb begin
		case (zone)
			zoneCtrl1: inputData = pinsSampled.player.player1[7:0];
			zoneCtrl2: inputData = pinsSampled.player.player2[7:0];
			zoneStatusB: begin
				inputData = {
					pinsSampled.systemMode,
					pinsSampled.writeProtect,
					pinsSampled.cardDetect,
					pinsSampled.player.player1[9:8],	// Start and select, player one
					pinsSampled.player.player2[9:8]		// Same for player two
				};
			end
			default: inputData = 8'h00;		// Not an input register
		endcase
	end

endmodule

`default_nettype wire

//--- c1SoundLatch.sv
`timescale 1ns/100ps
`default_nettype none

module c1SoundLatch import c1Pkg::*; (
	input wire CLK_68KCLK,
	input wire reset,
	input wire cpuBus_t bus,
	input wire c1Zone_e zone,
	input wire soundRead,
	input wire soundWrite,
	input wire soundClear,
	input wire [7:0] soundWriteData,
	output logic [7:0] commandData,
	output logic [7:0] replyData,
	output logic commandPending
);

	logic strobeSeen;		// AS on the previous clock
	logic cycleStart;		// First clock of a bus cycle
	logic commandLoad;		// 68k write to the command latch
	logic soundReadDone;	// Sound CPU read has finished

	assign cycleStart = bus.strobe & ~strobeSeen;

	// Once per bus cycle however long the wait
	assign commandLoad = cycleStart & ~bus.read & (zone == zoneSoundCom);

	always_ff @(posedge CLK_68KCLK) begin
		if (reset) begin
			strobeSeen <= 1'b0;
			soundReadDone <= 1'b0;
			commandData <= 8'h00;
			replyData <= 8'h00;
			commandPending <= 1'b0;
		end else begin
			strobeSeen <= bus.strobe;
			soundReadDone <= soundRead;

			// Main CPU to sound CPU
			if (commandLoad)
				commandData <= bus.writeData;

			// Sound CPU to main CPU
			if (soundClear)
				replyData <= 8'h00;
			else if (soundWrite)
				replyData <= soundWriteData;

			// A fresh command is never lost to a clear
			if (commandLoad)
				commandPending <= 1'b1;
			else if (soundClear || soundReadDone)
				commandPending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- c1Top.sv
`timescale 1ns/100ps
`default_nettype none

module c1Top import c1Pkg::*; (
	input wire CLK_68KCLK,
	input wire reset,
	input wire cpuBus_t bus,
	input wire playerInputs_t player,
	input wire [1:0] cardDetect,
	input wire writeProtect,
	input wire systemMode,
	input wire romWait,
	input wire [1:0] portWait,
	input wire portDtack,
	input wire soundRead,
	input wire soundWrite,
	input wire soundClear,
	input wire [7:0] soundWriteData,
	output memSelects_t selects,
	output logic dtack,
	output logic [7:0] readData,
	output logic [7:0] commandData,
	output logic commandPending,
	output c1Zone_e zone
);

	logic [7:0] inputData;		// Controller and status byte
	logic [7:0] replyData;		// Byte from the sound CPU

	c1AddressDecoder i_c1AddressDecoder (
		.bus(bus),
		.zone(zone),
		.selects(selects)
	);

	c1WaitStates i_c1WaitStates (
		.CLK_68KCLK(CLK_68KCLK),
		.reset(reset),
		.strobe(bus.strobe),
		.zone(zone),
		.romWait(romWait),
		.portWait(portWait),
		.portDtack(portDtack),
		.dtack(dtack)
	);

	c1InputPorts i_c1InputPorts (
		.CLK_68KCLK(CLK_68KCLK),
		.reset(reset),
		.player(player),
		.cardDetect(cardDetect),
		.writeProtect(writeProtect),
		.systemMode(systemMode),
		.zone(zone),
		.inputData(inputData)
	);

	c1SoundLatch i_c1SoundLatch (
		.CLK_68KCLK(CLK_68KCLK),
		.reset(reset),
		.bus(bus),
		.zone(zone),
		.soundRead(soundRead),
		.soundWrite(soundWrite),
		.soundClear(soundClear),
		.soundWriteData(soundWriteData),
		.commandData(commandData),
		.replyData(replyData),
		.commandPending(commandPending)
	);

	// Reply latch shares the bus with the input ports
	assign readData = (zone == zoneSoundCom) ? replyData : inputData;

endmodule

`default_nettype wire

//--- c1Tb.sv
`timescale 1ns/100ps
`default_nettype none

module c1Tb import c1Pkg::*; ();

	localparam int busCycles = 300;		// Random bus cycles in the main test
	localparam int resetCycles = 8;
	localparam int timeoutLimit = busCycles * 12 + resetCycles;	// Worst cycle is 11 clocks

	logic clk;
	logic reset;
	cpuBus_t bus;
	playerInputs_t player;
	logic [1:0] cardDetect;
	logic writeProtect;
	logic systemMode;
	logic romWait;
	logic [1:0] portWait;
	logic portDtack;
	logic soundRead;
	logic soundWrite;
	logic soundClear;
	logic [7:0] soundWriteData;
	memSelects_t selects;
	logic dtack;
	logic [7:0] readData;
	logic [7:0] commandData;
	logic commandPending;
	c1Zone_e zone;

	integer seed;
	int checkErrors;
	int otherErrors;
	int clockCount;
	string testName;

	// Reference state
	logic [7:0] modelCommand;
	logic [7:0] modelReply;
	logic modelPending;
	logic modelReadDone;		// soundRead one clock late
	logic modelStrobeSeen;		// AS on the last edge
	playerInputs_t modelPlayer;	// Settled pins
	logic [1:0] modelCard;
	logic modelProtect;
	logic modelMode;

	c1Top i_c1Top (
		.CLK_68KCLK(clk), .reset(reset), .bus(bus), .player(player),
		.cardDetect(cardDetect), .writeProtect(writeProtect), .systemMode(systemMode),
		.romWait(romWait), .portWait(portWait), .portDtack(portDtack),
		.soundRead(soundRead), .soundWrite(soundWrite), .soundClear(soundClear),
		.soundWriteData(soundWriteData), .selects(selects), .dtack(dtack),
		.readData(readData), .commandData(commandData),
		.commandPending(commandPending), .zone(zone)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		clockCount++;
		if (clockCount >= timeoutLimit) begin
			$display("Timeout: the run did not finish within %0d clocks", timeoutLimit);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic checkValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			checkErrors++;
			$display("CHECK FAILED %s %s: expected %h, actual %h", testName, what,
				expected, actual);
		end
	endtask

	// Memory map over A23..A17 in 128 KB steps
	function automatic c1Zone_e expectedZone(input cpuBus_t b);
		logic [2:0] ioReg;
		ioReg = b.addr[2:0];
		if (b.addr < 7'h08) return zoneRom;
		if (b.addr < 7'h10) return zoneWorkRam;
		if (b.addr < 7'h18) return zonePort;
		if (b.addr < 7'h20) begin
			if (ioReg == 3'd6) return zoneVideo;	// Video on either lane
			if (b.upperStrobe) begin
				case (ioReg)
					3'd0: return zoneCtrl1;
					3'd1: return zoneSoundCom;
					3'd2: return zoneCtrl2;
					3'd4: return zoneStatusB;
					default: return zoneNone;
				endcase
			end
			if (b.lowerStrobe && ioReg < 3'd2) return zoneDip;
			if (b.lowerStrobe && (ioReg == 3'd4 || ioReg == 3'd5)) return zoneBitWrite;
			return zoneNone;
		end
		if (b.addr < 7'h40) return zonePalette;
		if (b.addr < 7'h60) return zoneCard;
		if (b.addr < 7'h68) return zoneSysRom;
		if (b.addr < 7'h70) return zoneBackupRam;
		return zoneNone;
	endfunction

	function automatic memSelects_t expectedSelects(input cpuBus_t b);
		memSelects_t s;
		c1Zone_e z;
		logic rd;
		logic wr;
		logic [1:0] lanes;
		logic inIo;
		z = expectedZone(b);
		rd = b.strobe & b.read;
		wr = b.strobe & ~b.read;
		lanes = {b.upperStrobe, b.lowerStrobe};
		inIo = (b.addr >= 7'h18) && (b.addr <= 7'h1F);
		s = '0;
		s.romOe = (rd && z == zoneRom) ? lanes : 2'b00;
		s.portOe = (rd && z == zonePort) ? lanes : 2'b00;
		s.portWe = (wr && z == zonePort) ? lanes : 2'b00;
		s.workRamRead = (rd && z == zoneWorkRam) ? lanes : 2'b00;
		s.workRamWrite = (wr && z == zoneWorkRam) ? lanes : 2'b00;
		s.sysRomOe = (rd && z == zoneSysRom) ? lanes : 2'b00;
		s.backupRamOe = (rd && z == zoneBackupRam) ? lanes : 2'b00;
		s.backupRamWe = (wr && z == zoneBackupRam) ? lanes : 2'b00;
		s.videoOe = rd && b.upperStrobe && z == zoneVideo;
		s.videoWe = wr && b.upperStrobe && z == zoneVideo;
		s.cardOe = rd && b.lowerStrobe && z == zoneCard;	// Byte wide on the odd lane
		s.cardWe = wr && b.lowerStrobe && z == zoneCard;
		s.cardSelect = s.cardOe || s.cardWe;
		s.dipRead0 = rd && b.lowerStrobe && inIo && b.addr[2:0] == 3'd0;
		s.dipRead1 = rd && b.lowerStrobe && inIo && b.addr[2:0] == 3'd1;
		s.bitWrite0 = wr && b.lowerStrobe && inIo && b.addr[2:0] == 3'd4;
		s.bitWrite1 = wr && b.lowerStrobe && inIo && b.addr[2:0] == 3'd5;
		s.paletteSelect = b.strobe && z == zonePalette;
		return s;
	endfunction

	function automatic int expectedWait(input c1Zone_e z, input logic slowRom,
			input logic [1:0] portSetting);
		case (z)
			zoneRom: return slowRom ? romSlowWaitStates : 0;
			zonePort: return portSetting;
			zoneCard: return cardWaitStates;
			default: return 0;
		endcase
	endfunction

	// One clock of model update from the sampled pins followed by new pin values
	task automatic tick();
		logic loadCommand;
		logic [31:0] rnd;
		@(posedge clk);
		if (reset) begin
			modelCommand = 8'h00;
			modelReply = 8'h00;
			modelPending = 1'b0;
			modelReadDone = 1'b0;
			modelStrobeSeen = 1'b0;
			modelPlayer = '0;
			modelCard = 2'b00;
			modelProtect = 1'b0;
			modelMode = 1'b0;
		end else begin
			loadCommand = bus.strobe && !modelStrobeSeen && !bus.read &&
				expectedZone(bus) == zoneSoundCom;	// First clock of the write only
			if (loadCommand) modelCommand = bus.writeData;
			if (soundClear) modelReply = 8'h00;
			else if (soundWrite) modelReply = soundWriteData;
			if (loadCommand) modelPending = 1'b1;
			else if (soundClear || modelReadDone) modelPending = 1'b0;
			modelReadDone = soundRead;
			modelStrobeSeen = bus.strobe;
			modelPlayer = player;
			modelCard = cardDetect;
			modelProtect = writeProtect;
			modelMode = systemMode;
		end
		rnd = $random(seed);
		player <= rnd[19:0];
		cardDetect <= rnd[21:20];
		writeProtect <= rnd[22];
		systemMode <= rnd[23];
		soundWriteData <= rnd[31:24];
		rnd = $random(seed);
		soundRead <= (rnd[2:0] == 3'd0);	// Sparse sound CPU strobes
		soundWrite <= (rnd[5:3] == 3'd0);
		soundClear <= (rnd[9:6] == 4'd0);
	endtask

	// Sample at the falling edge away from the driving edge
	task automatic checkOutputs();
		c1Zone_e z;
		logic [7:0] expRead;
		@(negedge clk);
		z = expectedZone(bus);
		case (z)
			zoneSoundCom: expRead = modelReply;
			zoneCtrl1: expRead = modelPlayer.player1[7:0];
			zoneCtrl2: expRead = modelPlayer.player2[7:0];
			zoneStatusB: expRead = {modelMode, modelProtect, modelCard,
				modelPlayer.player1[9:8], modelPlayer.player2[9:8]};
			default: expRead = 8'h00;
		endcase
		checkValue("zone", z, zone);
		checkValue("selects", expectedSelects(bus), selects);
		checkValue("readData", expRead, readData);
		checkValue("commandData", modelCommand, commandData);
		checkValue("commandPending", modelPending, commandPending);
	endtask

	task automatic runBusCycle();
		cpuBus_t cycleBus;
		logic [31:0] rnd;
		logic slowRom;
		logic [1:0] portSetting;
		logic external;
		logic seen;
		int expectedClocks;
		int clocks;
		int raiseAt;
		int hold;
		rnd = $random(seed);
		case (rnd[31:30])
			2'd0: cycleBus.addr = 7'h19;				// Sound command latch
			2'd1: cycleBus.addr = {4'b0011, rnd[2:0]};	// Anywhere in I/O
			default: cycleBus.addr = rnd[6:0];
		endcase
		{cycleBus.upperStrobe, cycleBus.lowerStrobe} = (rnd[8:7] == 2'b00) ? 2'b11 : rnd[8:7];
		cycleBus.read = rnd[9];
		cycleBus.strobe = 1'b1;
		cycleBus.writeData = rnd[17:10];
		slowRom = rnd[18];
		portSetting = rnd[20:19];
		raiseAt = 1 + rnd[22:21];		// portDtack goes high after clock 1 to 4
		hold = $unsigned($random(seed)) % 3;	// Extra clocks with AS held
		external = (expectedZone(cycleBus) == zonePort) && (portSetting == 2'd3);
		expectedClocks = external ? raiseAt + 2 :
			expectedWait(expectedZone(cycleBus), slowRom, portSetting) + 2;
		tick();
		bus <= cycleBus;
		romWait <= slowRom;
		portWait <= portSetting;
		checkOutputs();
		seen = 1'b0;
		clocks = 0;
		while (!seen && clocks < 10) begin
			tick();
			clocks++;
			if (external && clocks == raiseAt) portDtack <= 1'b1;
			checkOutputs();
			if (dtack) seen = 1'b1;
		end
		if (!seen) begin
			otherErrors++;
			$display("%s: dtack never arrived for address %h", testName, cycleBus.addr);
		end else begin
			checkValue("dtack latency", expectedClocks, clocks);
			repeat (hold) begin
				tick();
				checkOutputs();
				checkValue("dtack held", 1'b1, dtack);
			end
		end
		tick();
		cycleBus.strobe = 1'b0;		// Release AS
		bus <= cycleBus;
		portDtack <= 1'b0;
		checkOutputs();
		if (seen) checkValue("dtack before release", 1'b1, dtack);
		tick();
		checkOutputs();
		checkValue("dtack release", 1'b0, dtack);
	endtask

	initial begin
		seed = 32'h9cdab4b9;
		checkErrors = 0;
		otherErrors = 0;
		clockCount = 0;
		reset = 1'b1;
		bus = '0;
		player = '0;
		cardDetect = 2'b00;
		writeProtect = 1'b0;
		systemMode = 1'b0;
		romWait = 1'b0;
		portWait = 2'b00;
		portDtack = 1'b0;
		soundRead = 1'b0;
		soundWrite = 1'b0;
		soundClear = 1'b0;
		soundWriteData = 8'h00;

		testName = "reset";
		tick();
		bus <= {7'h19, 1'b1, 1'b0, 1'b0, 1'b1, 8'h5a};	// Command write held through reset
		checkOutputs();
		checkValue("dtack", 1'b0, dtack);
		repeat (resetCycles - 2) begin
			tick();
			checkOutputs();
			checkValue("dtack", 1'b0, dtack);
		end
		tick();
		bus <= '0;
		reset <= 1'b0;		// Eighth edge still sees reset
		checkOutputs();
		checkValue("dtack", 1'b0, dtack);
		tick();
		checkOutputs();
		checkValue("dtack", 1'b0, dtack);

		testName = "random";
		repeat (busCycles) runBusCycle();

		$display("Errors: %0d value mismatches, %0d other failures", checkErrors, otherErrors);
		if (checkErrors == 0 && otherErrors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
c1Pkg.sv
c1AddressDecoder.sv
c1WaitStates.sv
c1InputPorts.sv
c1SoundLatch.sv
c1Top.sv
c1Tb.sv
